// File: verilog/fp_mul_pkg.sv
/*
 * single precision format constants, vector typedefs
 * and the pipeline stage register structs
 */
`default_nettype none

package fp_mul_pkg;

    localparam int EXP_W     = 8;
    localparam int FRAC_W    = 23;
    localparam int MANT_W    = FRAC_W + 1;   // with hidden bit
    localparam int EXP_BIAS  = 127;
    localparam int EXP_MAX   = 255;
    localparam int PRODUCT_W = 2 * MANT_W;

    localparam logic [31:0] CANON_NAN = 32'hFFC0_0000;

    typedef logic [31:0]           fp32_t;
    typedef logic signed [9:0]     exp_t;    // headroom for under/overflow
    typedef logic [MANT_W-1:0]     mant_t;
    typedef logic [PRODUCT_W-1:0]  product_t;

    // stage 1 -> stage 2
    typedef struct packed {
        logic     sign;
        exp_t     exp;
        product_t product;
        logic     is_special;
        fp32_t    special_value;
    } fp_product_s;

    // stage 2 -> stage 3
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        mant_t mant;
        logic  guard;
        logic  round_bit;
        logic  sticky;
        logic  is_special;
        fp32_t special_value;
    } fp_norm_s;

endpackage

`default_nettype wire

// File: verilog/leading_one_detector.sv
/*
 * combinational leading zero count that returns WIDTH for all zeros
 */
`timescale 1ns/10ps
`default_nettype none

module leading_one_detector #(
    parameter int WIDTH = 48
) (
    input  logic [WIDTH-1:0]            data,
    output logic [$clog2(WIDTH):0]      lz_count
);

    localparam int CNT_W = $clog2(WIDTH) + 1;

    // scan upward so the highest set bit wins
    always_comb begin
        lz_count = CNT_W'(WIDTH);
        for (int i = 0; i < WIDTH; i++) begin
            if (data[i])
                lz_count = CNT_W'(WIDTH - 1 - i);
        end
    end

endmodule

`default_nettype wire

// File: verilog/fp_mul_stage_product.sv
/*
 * first pipeline stage with operand classification, special case
 * resolution, significand product and combined exponent
 */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_stage_product import fp_mul_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  fp32_t       a,
    input  fp32_t       b,
    output fp_product_s stage_out
);

    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
    } fp_class_s;

    function automatic fp_class_s classify(input fp32_t x);
        logic [EXP_W-1:0]  e;
        logic [FRAC_W-1:0] f;
        fp_class_s         c;
        e      = x[FRAC_W +: EXP_W];
        f      = x[FRAC_W-1:0];
        c.zero = (e == '0) && (f == '0);
        c.inf  = (e == EXP_W'(EXP_MAX)) && (f == '0);
        c.nan  = (e == EXP_W'(EXP_MAX)) && (f != '0);
        return c;
    endfunction

    // hidden bit is 0 for a subnormal
    function automatic mant_t significand(input fp32_t x);
        return {x[FRAC_W +: EXP_W] != '0, x[FRAC_W-1:0]};
    endfunction

    // subnormals use exponent 1
    function automatic exp_t eff_exp(input fp32_t x);
        logic [EXP_W-1:0] e;
        e = x[FRAC_W +: EXP_W];
        if (e == '0)
            return exp_t'(1);
        return exp_t'(e);
    endfunction

    fp_class_s   cls_a, cls_b;
    fp_product_s nxt;
    logic        sign;

    assign cls_a = classify(a);
    assign cls_b = classify(b);
    assign sign  = a[31] ^ b[31];

    always_comb begin
        nxt      = '0;
        nxt.sign = sign;
        if (cls_a.nan || cls_b.nan) begin
            nxt.is_special    = 1'b1;
            nxt.special_value = CANON_NAN;
        end else if ((cls_a.inf && cls_b.zero) || (cls_a.zero && cls_b.inf)) begin
            nxt.is_special    = 1'b1;
            nxt.special_value = CANON_NAN;
        end else if (cls_a.inf || cls_b.inf) begin
            nxt.is_special    = 1'b1;
            nxt.special_value = {sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
        end else if (cls_a.zero || cls_b.zero) begin
            nxt.is_special    = 1'b1;
            nxt.special_value = {sign, {(EXP_W + FRAC_W){1'b0}}};
        end else begin
            nxt.product = product_t'(significand(a)) * product_t'(significand(b));
            nxt.exp     = eff_exp(a) + eff_exp(b) - exp_t'(EXP_BIAS) + exp_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            stage_out <= '0;
        else
            stage_out <= nxt;
    end

endmodule

`default_nettype wire

// File: verilog/fp_mul_stage_normalize.sv
/*
 * second pipeline stage that left normalizes through the leading one
 * detector, denormalizes right on underflow and extracts guard/round/sticky
 */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_stage_normalize import fp_mul_pkg::*; #(
    parameter int PRODUCT_WIDTH = 48
) (
    input  logic        clk,
    input  logic        rst,
    input  fp_product_s stage_in,
    output fp_norm_s    stage_out
);

    localparam int LZ_W       = $clog2(PRODUCT_WIDTH) + 1;
    localparam int MAX_RSHIFT = PRODUCT_WIDTH + 2;
    localparam int RSH_W      = $clog2(MAX_RSHIFT + 1);
    localparam int EXT_W      = PRODUCT_WIDTH + MAX_RSHIFT;

    logic [PRODUCT_WIDTH-1:0] prod;
    logic [LZ_W-1:0]          lz;
    logic [PRODUCT_WIDTH-1:0] shifted;
    logic [EXT_W-1:0]         ext;
    logic [PRODUCT_WIDTH-1:0] top;
    logic [RSH_W-1:0]         rshift;
    exp_t                     exp_norm;
    logic                     is_zero;
    fp_norm_s                 nxt;

    assign prod = stage_in.product;

    leading_one_detector #(
        .WIDTH(PRODUCT_WIDTH)
    ) u_lod (
        .data(prod),
        .lz_count(lz)
    );

    assign is_zero = (lz == LZ_W'(PRODUCT_WIDTH));

    always_comb begin
        rshift   = '0;
        shifted  = prod << lz;   // leading one to the top bit
        exp_norm = stage_in.exp - exp_t'(lz);
        ext      = {shifted, {MAX_RSHIFT{1'b0}}};
        if (exp_norm < exp_t'(1)) begin
            if (exp_norm < exp_t'(1 - MAX_RSHIFT))
                rshift = RSH_W'(MAX_RSHIFT);
            else
                rshift = RSH_W'(exp_t'(1) - exp_norm);
            ext      = ext >> rshift;   // low part collects shifted out bits
            exp_norm = '0;
        end
        top = ext[EXT_W-1 -: PRODUCT_WIDTH];

        nxt               = '0;
        nxt.sign          = stage_in.sign;
        nxt.is_special    = stage_in.is_special;
        nxt.special_value = stage_in.special_value;
        if (!is_zero) begin
            nxt.exp       = exp_norm;
            nxt.mant      = top[PRODUCT_WIDTH-1 -: MANT_W];
            nxt.guard     = top[PRODUCT_WIDTH-MANT_W-1];
            nxt.round_bit = top[PRODUCT_WIDTH-MANT_W-2];
            nxt.sticky    = (|top[PRODUCT_WIDTH-MANT_W-3:0]) | (|ext[MAX_RSHIFT-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            stage_out <= '0;
        else
            stage_out <= nxt;
    end

endmodule

`default_nettype wire

// File: verilog/fp_mul_stage_round.sv
/*
 * third pipeline stage with round to nearest even, overflow to infinity
 * and packing of the IEEE word
 */
`timescale 1ns/10ps
`default_nettype none

module fp_mul_stage_round import fp_mul_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  fp_norm_s stage_in,
    output fp32_t    z
);

    logic            round_up;
    logic [MANT_W:0] sum;
    mant_t           mant_r;
    exp_t            exp_r;
    fp32_t           z_next;

    always_comb begin
        // ties go to the even mantissa
        round_up = stage_in.guard & (stage_in.round_bit | stage_in.sticky | stage_in.mant[0]);
        sum      = {1'b0, stage_in.mant} + {{MANT_W{1'b0}}, round_up};

        if (sum[MANT_W]) begin   // renormalize on carry out
            mant_r = sum[MANT_W:1];
            exp_r  = stage_in.exp + exp_t'(1);
        end else begin
            mant_r = sum[MANT_W-1:0];
            exp_r  = stage_in.exp;
        end

        // subnormal rounded up into the normal range
        if (exp_r == '0 && mant_r[MANT_W-1])
            exp_r = exp_t'(1);

        if (stage_in.is_special)
            z_next = stage_in.special_value;
        else if (exp_r >= exp_t'(EXP_MAX))
            z_next = {stage_in.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
        else
            z_next = {stage_in.sign, exp_r[EXP_W-1:0], mant_r[FRAC_W-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst)
            z <= '0;
        else
            z <= z_next;
    end

endmodule

`default_nettype wire

// File: verilog/fp_multiplier.sv
/*
 * three stage pipelined single precision multiplier with latency 3
 */
`timescale 1ns/10ps
`default_nettype none

module fp_multiplier import fp_mul_pkg::*; #(
    parameter int PRODUCT_WIDTH = PRODUCT_W
) (
    input  logic  clk,
    input  logic  rst,
    input  fp32_t input_a,
    input  fp32_t input_b,
    output fp32_t output_z
);

    fp_product_s product_reg;   // stage 1 -> 2
    fp_norm_s    norm_reg;      // stage 2 -> 3

    fp_mul_stage_product u_product (
        .clk(clk),
        .rst(rst),
        .a(input_a),
        .b(input_b),
        .stage_out(product_reg)
    );

    fp_mul_stage_normalize #(
        .PRODUCT_WIDTH(PRODUCT_WIDTH)
    ) u_normalize (
        .clk(clk),
        .rst(rst),
        .stage_in(product_reg),
        .stage_out(norm_reg)
    );

    fp_mul_stage_round u_round (
        .clk(clk),
        .rst(rst),
        .stage_in(norm_reg),
        .z(output_z)
    );

endmodule

`default_nettype wire

// File: test/fp_multiplier_assertions.sv
/*
 * concurrent checks on the multiplier output, bound to fp_multiplier
 */
`timescale 1ns/10ps
`default_nettype none

module fp_multiplier_assertions import fp_mul_pkg::*; (
    input logic  clk,
    input logic  rst,
    input fp32_t input_a,
    input fp32_t input_b,
    input fp32_t output_z
);

    function automatic logic is_nan(input fp32_t x);
        return (x[30:23] == 8'hFF) && (x[22:0] != '0);
    endfunction

    output_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(output_z)
    ) else $error("output_z is unknown after reset");

    // three clean edges needed so the operands went through all stages
    nan_propagates: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)
            && (is_nan($past(input_a, 3)) || is_nan($past(input_b, 3))))
            |-> output_z == CANON_NAN
    ) else $error("nan operand did not give the canonical nan");

    nan_is_canonical: assert property (
        @(posedge clk) disable iff (rst)
        is_nan(output_z) |-> output_z == CANON_NAN
    ) else $error("non canonical nan on output_z: %08h", output_z);

endmodule

bind fp_multiplier fp_multiplier_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .input_a(input_a),
    .input_b(input_b),
    .output_z(output_z)
);

`default_nettype wire

// File: test/fp_multiplier_tb.sv
/*
 * testbench for the pipelined single precision multiplier
 * reference model, latency queue, directed and random operand pairs
 */
`timescale 1ns/10ps
`default_nettype none

module fp_multiplier_tb import fp_mul_pkg::*; ();

    localparam int LATENCY      = 3;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_PAIRS = 2000;
    localparam int SEED         = 26552;

    // one operand pair in flight
    typedef struct packed {
        logic [31:0] drive_cycle;
        fp32_t       a;
        fp32_t       b;
    } pending_s;

    logic        clk = 1'b0;
    logic        rst;
    fp32_t       input_a;
    fp32_t       input_b;
    fp32_t       output_z;

    fp32_t       vec_a[$];
    fp32_t       vec_b[$];
    pending_s    pending_q[$];
    logic [31:0] cycle_count = '0;
    logic [31:0] cycle_limit = 32'hFFFF_FFFF;
    logic        results_started = 1'b0;

    fp_multiplier u_dut (
        .clk(clk),
        .rst(rst),
        .input_a(input_a),
        .input_b(input_b),
        .output_z(output_z)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 32'd1;

    // expected product straight from the IEEE rules with round to nearest even
    function automatic fp32_t ref_fp_mul(input fp32_t a, input fp32_t b);
        logic        s;
        int          ea, eb, e;
        logic [22:0] fa, fb;
        logic [47:0] p;
        logic [23:0] mant;
        logic [24:0] sum;
        logic        g, r, st;
        int          msb, shift, i;
        s  = a[31] ^ b[31];
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        fa = a[22:0];
        fb = b[22:0];
        if ((ea == 255 && fa != '0) || (eb == 255 && fb != '0))
            return CANON_NAN;
        if ((ea == 255 && eb == 0 && fb == '0) || (eb == 255 && ea == 0 && fa == '0))
            return CANON_NAN;
        if (ea == 255 || eb == 255)
            return {s, 8'hFF, 23'd0};
        if ((ea == 0 && fa == '0) || (eb == 0 && fb == '0))
            return {s, 31'd0};

        p = {24'd0, ea != 0, fa} * {24'd0, eb != 0, fb};
        e = (ea == 0 ? 1 : ea) + (eb == 0 ? 1 : eb) - EXP_BIAS + 1;

        msb = 47;   // p is nonzero here
        while (!p[msb])
            msb--;
        p    = p << (47 - msb);
        e    = e - (47 - msb);
        mant = p[47:24];
        g    = p[23];
        r    = p[22];
        st   = |p[21:0];

        // on underflow shift right one place at a time into sticky
        if (e < 1) begin
            shift = 1 - e;
            if (shift > 50)
                shift = 50;
            for (i = 0; i < shift; i++) begin
                st   = st | r;
                r    = g;
                g    = mant[0];
                mant = mant >> 1;
            end
            e = 0;
        end

        if (g && (r || st || mant[0]))
            sum = {1'b0, mant} + 25'd1;
        else
            sum = {1'b0, mant};
        if (sum[24]) begin
            mant = sum[24:1];
            e    = e + 1;
        end else begin
            mant = sum[23:0];
        end
        if (e == 0 && mant[23])
            e = 1;   // rounded up out of the subnormal range
        if (e >= EXP_MAX)
            return {s, 8'hFF, 23'd0};
        return {s, e[7:0], mant[22:0]};
    endfunction

    task automatic check_fp32(input string name, input fp32_t expected, input fp32_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED t=%0t %s expected=%08h actual=%08h",
                     $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic push_pair(input fp32_t a, input fp32_t b);
        vec_a.push_back(a);
        vec_b.push_back(b);
    endtask

    // exponent mostly normal and away from the range limits
    function automatic fp32_t draw_operand();
        logic        s;
        logic [7:0]  e;
        logic [22:0] f;
        int unsigned pick;
        s    = 1'($urandom());
        f    = 23'($urandom());
        pick = $urandom_range(99, 0);
        if (pick < 90)
            e = 8'($urandom_range(190, 64));
        else if (pick < 96)
            e = 8'($urandom_range(254, 1));
        else if (pick < 98)
            e = 8'h00;
        else
            e = 8'hFF;
        return {s, e, f};
    endfunction

    task automatic directed_set();
        // nan, inf times zero, inf times finite, signed zeros
        push_pair(32'h7FC0_0000, 32'h3F80_0000);
        push_pair(32'h7F80_0001, 32'h0000_0000);
        push_pair(32'hFFFF_FFFF, 32'h7F80_0000);
        push_pair(32'h7F80_0000, 32'h0000_0000);
        push_pair(32'h8000_0000, 32'hFF80_0000);
        push_pair(32'h7F80_0000, 32'hBF80_0000);
        push_pair(32'hFF80_0000, 32'h0000_0001);
        push_pair(32'h0000_0000, 32'h3F80_0000);
        push_pair(32'h8000_0000, 32'h4049_0FDB);
        push_pair(32'h0000_0000, 32'h8000_0001);
        // subnormal operands
        push_pair(32'h0040_0000, 32'h4000_0000);
        push_pair(32'h0000_0001, 32'h4B00_0000);
        push_pair(32'h0012_3456, 32'hBFC0_0000);
        push_pair(32'h0000_0001, 32'h0000_0001);
        push_pair(32'h8000_0001, 32'h0040_0000);
        // normal products landing in the subnormal range
        push_pair(32'h1F80_0000, 32'h1F80_0000);
        push_pair(32'h0080_0000, 32'h3F00_0000);
        push_pair(32'h0080_0001, 32'h3F00_0000);
        push_pair(32'h0080_0003, 32'h3F00_0000);
        push_pair(32'h0DA2_4260, 32'h3210_1234);
        // rounding up into the normal range
        push_pair(32'h007F_FFFF, 32'h3F80_0001);
        push_pair(32'h00FF_FFFF, 32'h3F00_0000);
        // exact ties with odd and even low bit
        push_pair(32'h3F80_0001, 32'h3FC0_0000);
        push_pair(32'h3F80_0003, 32'h3FC0_0000);
        // mantissa carry out while rounding
        push_pair(32'h3FFF_FFFF, 32'h3F80_0001);
        push_pair(32'h3FB5_04F3, 32'h3FB5_04F3);
        // overflow to infinity
        push_pair(32'h7F00_0000, 32'h4000_0000);
        push_pair(32'h7F7F_FFFF, 32'h3F80_0001);
        push_pair(32'hFF00_0000, 32'h7F00_0000);
        push_pair(32'h7F7F_FFFF, 32'h3F80_0000);
    endtask

    task automatic random_set(input int count);
        fp32_t a;
        fp32_t b;
        for (int n = 0; n < count; n++) begin
            a = draw_operand();
            b = draw_operand();
            push_pair(a, b);
        end
    endtask

    // one pair per edge right after reset
    initial begin
        pending_s entry;
        void'($urandom(SEED));
        rst     <= 1'b1;
        input_a <= '0;
        input_b <= '0;
        directed_set();
        random_set(RANDOM_PAIRS);
        cycle_limit = 32'(vec_a.size() + LATENCY + 20);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        foreach (vec_a[i]) begin
            input_a           <= vec_a[i];
            input_b           <= vec_b[i];
            entry.drive_cycle = cycle_count;
            entry.a           = vec_a[i];
            entry.b           = vec_b[i];
            pending_q.push_back(entry);
            @(posedge clk);
        end
        while (pending_q.size() != 0)
            @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

    // output read at the edge is the one left by the previous edge
    always @(posedge clk) begin
        pending_s head;
        if (pending_q.size() != 0
                && pending_q[0].drive_cycle + 32'(LATENCY + 1) == cycle_count) begin
            head            = pending_q.pop_front();
            results_started = 1'b1;
            check_fp32("output_z", ref_fp_mul(head.a, head.b), output_z);
        end else if (!results_started && cycle_count >= 32'd1) begin
            check_fp32("output_z", '0, output_z);   // reset and pipeline fill
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d results never compared",
                     cycle_count, pending_q.size());
            $display("=== FAIL ===");
            $fatal(1, "simulation timeout");
        end
    end

endmodule

`default_nettype wire

// File: tb.f
verilog/fp_mul_pkg.sv
verilog/leading_one_detector.sv
verilog/fp_mul_stage_product.sv
verilog/fp_mul_stage_normalize.sv
verilog/fp_mul_stage_round.sv
verilog/fp_multiplier.sv
test/fp_multiplier_assertions.sv
test/fp_multiplier_tb.sv

// File: run.sh
#!/bin/sh
# build and run the multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f \
    --top-module fp_multiplier_tb -Mdir obj_dir

# keep running past an assertion so the testbench reports the failure
./obj_dir/Vfp_multiplier_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1
